// ==== run.sh ====
#!/bin/sh
# Builds the merge sorter testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module merge_sorter_tb \
    -o merge_sorter_sim

# The run passes only if the pass line shows up in the output
output=$(./obj_dir/merge_sorter_sim 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
else
    exit 1
fi

// ==== sources.f ====
src/merge_pkg.sv
src/run_buffer.sv
src/merging_core.sv
src/result_port.sv
src/merge_sorter_top.sv
testbench/merge_sorter_assert.sv
testbench/merge_sorter_tb.sv

// ==== src/merge_pkg.sv ====
// Package merge_pkg with the key type, the default run buffer depth and the state enums
package merge_pkg;

    // Width of one sort key in bits
    parameter int KEY_WIDTH = 16;

    // A sort key, compared as an unsigned number
    typedef logic [KEY_WIDTH-1:0] key_t;

    // Default number of words that each input run buffer holds
    // The depth must be a power of two and at least 2
    parameter int BUFFER_DEPTH_DEFAULT = 4;

    // States of the merging core
    // idle waits for the first heads of a new pair of runs
    // merging compares both heads and takes the smaller one
    // drain_a and drain_b forward the one run that is left after the other ended
    typedef enum logic [1:0] {
        idle,
        merging,
        drain_a,
        drain_b
    } merge_state_t;

    // Phases of the four-phase req/ack handshakes
    // The receiver in run_buffer uses wait_req, ack_high and wait_release
    // The sender in result_port uses empty, req_high and wait_ack_low
    typedef enum logic [2:0] {
        wait_req,
        ack_high,
        wait_release,
        empty,
        req_high,
        wait_ack_low
    } port_state_t;

endpackage

// ==== src/merge_sorter_top.sv ====
// Module merge_sorter_top with two run buffers, the merging core and the result port
module merge_sorter_top #(
    parameter int BUFFER_DEPTH = merge_pkg::BUFFER_DEPTH_DEFAULT
) (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            a_req,
    input  logic            a_last,
    input  merge_pkg::key_t a_key,
    output logic            a_ack,
    input  logic            b_req,
    input  logic            b_last,
    input  merge_pkg::key_t b_key,
    output logic            b_ack,
    output logic            out_req,
    output logic            out_last,
    output merge_pkg::key_t out_key,
    input  logic            out_ack
);

    // Head streams from the buffers into the core
    logic            a_valid;
    logic            a_last_head;
    merge_pkg::key_t a_key_head;
    logic            a_ready;
    logic            b_valid;
    logic            b_last_head;
    merge_pkg::key_t b_key_head;
    logic            b_ready;

    // Merged stream from the core into the result port
    logic            m_valid;
    logic            m_last;
    merge_pkg::key_t m_key;
    logic            m_ready;

    // Run A receiver
    run_buffer #(
        .DEPTH (BUFFER_DEPTH)
    ) buf_a (
        .clock      (clock),
        .rst_n      (rst_n),
        .req        (a_req),
        .last       (a_last),
        .key        (a_key),
        .ack        (a_ack),
        .head_valid (a_valid),
        .head_last  (a_last_head),
        .head_key   (a_key_head),
        .head_ready (a_ready)
    );

    // Run B receiver
    run_buffer #(
        .DEPTH (BUFFER_DEPTH)
    ) buf_b (
        .clock      (clock),
        .rst_n      (rst_n),
        .req        (b_req),
        .last       (b_last),
        .key        (b_key),
        .ack        (b_ack),
        .head_valid (b_valid),
        .head_last  (b_last_head),
        .head_key   (b_key_head),
        .head_ready (b_ready)
    );

    merging_core core (
        .clock   (clock),
        .rst_n   (rst_n),
        .a_valid (a_valid),
        .a_last  (a_last_head),
        .a_key   (a_key_head),
        .a_ready (a_ready),
        .b_valid (b_valid),
        .b_last  (b_last_head),
        .b_key   (b_key_head),
        .b_ready (b_ready),
        .m_valid (m_valid),
        .m_last  (m_last),
        .m_key   (m_key),
        .m_ready (m_ready)
    );

    result_port port (
        .clock    (clock),
        .rst_n    (rst_n),
        .m_valid  (m_valid),
        .m_last   (m_last),
        .m_key    (m_key),
        .m_ready  (m_ready),
        .out_req  (out_req),
        .out_last (out_last),
        .out_key  (out_key),
        .out_ack  (out_ack)
    );

endmodule

// ==== src/merging_core.sv ====
// Module merging_core, a stable two-way merge of two sorted runs with run-end handling
module merging_core (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            a_valid,
    input  logic            a_last,
    input  merge_pkg::key_t a_key,
    output logic            a_ready,
    input  logic            b_valid,
    input  logic            b_last,
    input  merge_pkg::key_t b_key,
    output logic            b_ready,
    output logic            m_valid,
    output logic            m_last,
    output merge_pkg::key_t m_key,
    input  logic            m_ready
);

    merge_pkg::merge_state_t state;
    merge_pkg::merge_state_t state_next;
    logic                    out_free;
    logic                    take_a;
    logic                    take_b;
    logic                    a_wins;
    logic                    draining;

    // The output register can load when it is empty or is handing its word over now
    assign out_free = !m_valid || m_ready;

    // Ties go to A, which keeps equal keys in arrival order
    assign a_wins = (a_key <= b_key);

    // In the drain states only the remaining run is forwarded
    assign draining = (state == merge_pkg::drain_a) || (state == merge_pkg::drain_b);

    // Pick the word to move this cycle
    always_comb begin
        take_a = 1'b0;
        take_b = 1'b0;
        case (state)
            merge_pkg::merging: begin
                // Both heads must be present so the compare never sees stale data
                if (a_valid && b_valid && out_free) begin
                    take_a = a_wins;
                    take_b = !a_wins;
                end
            end
            merge_pkg::drain_a: begin
                take_a = a_valid && out_free;
            end
            merge_pkg::drain_b: begin
                take_b = b_valid && out_free;
            end
            default: begin
                take_a = 1'b0;
                take_b = 1'b0;
            end
        endcase
    end

    // Popping a buffer is the same event as taking its head
    assign a_ready = take_a;
    assign b_ready = take_b;

    // Run-end handling
    always_comb begin
        state_next = state;
        case (state)
            merge_pkg::idle: begin
                // A word on either input starts the next pair of runs
                if (a_valid || b_valid) begin
                    state_next = merge_pkg::merging;
                end
            end
            merge_pkg::merging: begin
                // The run that just ended leaves the other one to drain
                if (take_a && a_last) begin
                    state_next = merge_pkg::drain_b;
                end else if (take_b && b_last) begin
                    state_next = merge_pkg::drain_a;
                end
            end
            merge_pkg::drain_a: begin
                if (take_a && a_last) begin
                    state_next = merge_pkg::idle;
                end
            end
            merge_pkg::drain_b: begin
                if (take_b && b_last) begin
                    state_next = merge_pkg::idle;
                end
            end
            default: begin
                state_next = merge_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= merge_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // Output valid, cleared by reset and held while the port is busy
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (out_free) begin
            m_valid <= take_a || take_b;
        end
    end

    // Output payload, loaded only when a word is taken
    always_ff @(posedge clock) begin
        if (take_a || take_b) begin
            m_key <= take_a ? a_key : b_key;
            // Only the last word of the run that drains closes the merged run
            m_last <= draining && (take_a ? a_last : b_last);
        end
    end

endmodule

// ==== src/result_port.sv ====
// Module result_port, a one-word holding register with a four-phase req/ack sender
module result_port (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            m_valid,
    input  logic            m_last,
    input  merge_pkg::key_t m_key,
    output logic            m_ready,
    output logic            out_req,
    output logic            out_last,
    output merge_pkg::key_t out_key,
    input  logic            out_ack
);

    merge_pkg::port_state_t state;
    logic                   accept;

    // A new word is taken only while no handshake is running
    assign m_ready = (state == merge_pkg::empty);
    assign accept  = m_valid && m_ready;

    // Send side of the four-phase handshake
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= merge_pkg::empty;
            out_req <= 1'b0;
        end else begin
            case (state)
                merge_pkg::empty: begin
                    if (accept) begin
                        out_req <= 1'b1;
                        state   <= merge_pkg::req_high;
                    end
                end
                merge_pkg::req_high: begin
                    // The consumer has taken the word
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= merge_pkg::wait_ack_low;
                    end
                end
                merge_pkg::wait_ack_low: begin
                    // The next word may go out once ack has returned low
                    if (!out_ack) begin
                        state <= merge_pkg::empty;
                    end
                end
                default: begin
                    out_req <= 1'b0;
                    state   <= merge_pkg::empty;
                end
            endcase
        end
    end

    // Held word, stable for the whole time out_req is high
    always_ff @(posedge clock) begin
        if (accept) begin
            out_key  <= m_key;
            out_last <= m_last;
        end
    end

endmodule

// ==== src/run_buffer.sv ====
// Module run_buffer with a four-phase req/ack receiver and a FIFO of key and last pairs
module run_buffer #(
    parameter int DEPTH = 4
) (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           req,
    input  logic           last,
    input  merge_pkg::key_t key,
    output logic           ack,
    output logic           head_valid,
    output logic           head_last,
    output merge_pkg::key_t head_key,
    input  logic           head_ready
);

    localparam int ADDR_WIDTH = $clog2(DEPTH);

    // Pointers carry one extra wrap bit so that full and empty can be told apart
    typedef logic [ADDR_WIDTH:0] ptr_t;

    merge_pkg::port_state_t state;
    merge_pkg::key_t        key_mem [DEPTH];
    logic                   last_mem [DEPTH];
    ptr_t                   wr_ptr;
    ptr_t                   rd_ptr;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic                   push;
    logic                   pop;

    // Equal low bits with different wrap bits means every slot is taken
    assign fifo_full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                        (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    assign fifo_empty = (wr_ptr == rd_ptr);

    // The word is written one edge after ack rises, while req still holds it stable
    assign push = (state == merge_pkg::ack_high);
    assign pop  = head_valid && head_ready;

    // The oldest word is offered to the core as a stream
    assign head_valid = !fifo_empty;
    assign head_key   = key_mem[rd_ptr[ADDR_WIDTH-1:0]];
    assign head_last  = last_mem[rd_ptr[ADDR_WIDTH-1:0]];

    // Receive side of the four-phase handshake
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= merge_pkg::wait_req;
            ack   <= 1'b0;
        end else begin
            case (state)
                merge_pkg::wait_req: begin
                    // A full FIFO keeps ack low, so the producer stalls here
                    if (req && !fifo_full) begin
                        ack   <= 1'b1;
                        state <= merge_pkg::ack_high;
                    end
                end
                merge_pkg::ack_high: begin
                    // Room was checked before ack rose and only this block fills the FIFO
                    state <= merge_pkg::wait_release;
                end
                merge_pkg::wait_release: begin
                    // Ack falls once the producer has dropped req
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= merge_pkg::wait_req;
                    end
                end
                default: begin
                    ack   <= 1'b0;
                    state <= merge_pkg::wait_req;
                end
            endcase
        end
    end

    // FIFO pointers
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // FIFO storage holds payload only
    always_ff @(posedge clock) begin
        if (push) begin
            key_mem[wr_ptr[ADDR_WIDTH-1:0]]  <= key;
            last_mem[wr_ptr[ADDR_WIDTH-1:0]] <= last;
        end
    end

endmodule

// ==== testbench/merge_input.txt ====
# Columns: test name, run A as a word count and its keys, then run B in the same form,
# then the expected merged run as a word count and its keys; all keys are decimal
# Keys from both runs interleave
interleaved 3 1 4 9 3 2 3 10 6 1 2 3 4 9 10

# One equal key on each side
tie_single 1 5 1 5 2 5 5

# The tied A word is the last of A, so B drains after it
tie_last_a 1 4 2 4 6 3 4 4 6

# Several equal keys on both sides
tie_many 4 2 4 4 7 3 4 4 6 7 2 4 4 4 4 6 7

# Every key is the same
tie_all 3 3 3 3 2 3 3 5 3 3 3 3 3

# A ends after one small key and B drains
early_a 1 0 8 1 2 3 4 5 6 7 8 9 0 1 2 3 4 5 6 7 8

# B ends after one small key and A drains
early_b 6 10 20 30 40 50 60 1 5 7 5 10 20 30 40 50 60

# All of A comes before all of B
a_before_b 5 1 2 3 4 5 5 6 7 8 9 10 10 1 2 3 4 5 6 7 8 9 10

# All of B comes before all of A
b_before_a 3 50 60 70 6 1 2 3 4 5 6 9 1 2 3 4 5 6 50 60 70

# Runs longer than the buffers, strictly alternating
long_mix 7 1 3 5 7 9 11 13 7 2 4 6 8 10 12 14 14 1 2 3 4 5 6 7 8 9 10 11 12 13 14

# A long run of A between the two words of B
long_skew 12 1 2 3 4 5 6 7 8 9 10 11 12 2 0 13 14 0 1 2 3 4 5 6 7 8 9 10 11 12 13

# A long run of B around the single word of A
long_b_drain 1 12 12 1 2 3 4 5 6 7 8 9 10 11 13 13 1 2 3 4 5 6 7 8 9 10 11 12 13

# Smallest and largest keys
key_limits 2 65534 65535 2 0 65535 4 0 65534 65535 65535

# One word on each side with B smaller
one_each 1 7 1 3 2 3 7

# A long run of one value against a single equal word
dup_runs 6 8 8 8 8 8 8 1 8 7 8 8 8 8 8 8 8

# Wide keys, strictly alternating
spaced 3 1000 2000 3000 3 1500 2500 3500 6 1000 1500 2000 2500 3000 3500

# Zero keys only
zeros 2 0 0 1 0 3 0 0 0

// ==== testbench/merge_sorter_assert.sv ====
// Module merge_sorter_assert with concurrent handshake assertions and its bind into the top
module merge_sorter_assert (
    input logic            clock,
    input logic            rst_n,
    input logic            a_req,
    input logic            a_ack,
    input logic            b_req,
    input logic            b_ack,
    input logic            out_req,
    input logic            out_ack,
    input merge_pkg::key_t out_key,
    input logic            m_valid,
    input logic            m_ready
);

    // The result port keeps req up until the consumer answers
    out_req_held: assert property (@(posedge clock) disable iff (!rst_n)
        out_req && !out_ack |=> out_req)
        else $error("out_req dropped before out_ack was seen high");

    // The held word must not change under a raised req
    out_key_stable: assert property (@(posedge clock) disable iff (!rst_n)
        out_req && $past(out_req) |-> $stable(out_key))
        else $error("out_key changed while out_req was high");

    // A receiver answers only a raised req
    a_ack_follows_req: assert property (@(posedge clock) disable iff (!rst_n)
        !a_req && !a_ack |=> !a_ack)
        else $error("a_ack rose while a_req was low");

    b_ack_follows_req: assert property (@(posedge clock) disable iff (!rst_n)
        !b_req && !b_ack |=> !b_ack)
        else $error("b_ack rose while b_req was low");

    // Core output is a stream and may not withdraw a word
    m_valid_held: assert property (@(posedge clock) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid)
        else $error("m_valid dropped before m_ready");

endmodule

bind merge_sorter_top merge_sorter_assert handshake_checks (
    .clock   (clock),
    .rst_n   (rst_n),
    .a_req   (a_req),
    .a_ack   (a_ack),
    .b_req   (b_req),
    .b_ack   (b_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_key (out_key),
    .m_valid (m_valid),
    .m_ready (m_ready)
);

// ==== testbench/merge_sorter_tb.sv ====
// Testbench merge_sorter_tb with clock, reset, run drivers, result consumer, checks and watchdog
module merge_sorter_tb;

    localparam int MAX_TESTS = 32;
    localparam int MAX_WORDS = 32;

    // Run slot 0 holds run A, slot 1 run B and slot 2 the expected merged run
    localparam int RUN_EXPECTED = 2;

    logic            clock;
    logic            rst_n;
    logic            req_in [2];
    logic            last_in [2];
    merge_pkg::key_t key_in [2];
    logic            ack_out [2];
    logic            out_req;
    logic            out_last;
    merge_pkg::key_t out_key;
    logic            out_ack;

    string           test_name [MAX_TESTS];
    int              run_count [MAX_TESTS][3];
    merge_pkg::key_t run_keys [MAX_TESTS][3][MAX_WORDS];
    int              num_tests;
    int              total_words;
    int              watchdog_cycles;
    int              errors;
    logic [31:0]     rng_state;

    merge_sorter_top #(
        .BUFFER_DEPTH (merge_pkg::BUFFER_DEPTH_DEFAULT)
    ) dut (
        .clock    (clock),
        .rst_n    (rst_n),
        .a_req    (req_in[0]),
        .a_last   (last_in[0]),
        .a_key    (key_in[0]),
        .a_ack    (ack_out[0]),
        .b_req    (req_in[1]),
        .b_last   (last_in[1]),
        .b_key    (key_in[1]),
        .b_ack    (ack_out[1]),
        .out_req  (out_req),
        .out_last (out_last),
        .out_key  (out_key),
        .out_ack  (out_ack)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // The upper LCG bits are better mixed than the low ones
    function automatic int random_delay(input int max_cycles);
        logic [31:0] value;
        value = lcg_next();
        return int'(value[31:16]) % (max_cycles + 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // Each test line is a name followed by three runs, each a count and then its keys
    task automatic load_tests();
        int    fd;
        int    code;
        int    r;
        int    i;
        int    n;
        int    value;
        string token;
        string rest;
        fd = $fopen("testbench/merge_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file testbench/merge_input.txt");
            errors++;
            return;
        end
        code = $fscanf(fd, "%s", token);
        while (code == 1 && num_tests < MAX_TESTS) begin
            if (token.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else begin
                test_name[num_tests] = token;
                for (r = 0; r < 3; r++) begin
                    code = $fscanf(fd, "%d", n);
                    if (code != 1 || n < 1 || n > MAX_WORDS) begin
                        $display("Test %s has a bad word count in the test file", token);
                        errors++;
                        $fclose(fd);
                        return;
                    end
                    run_count[num_tests][r] = n;
                    for (i = 0; i < n; i++) begin
                        code = $fscanf(fd, "%d", value);
                        run_keys[num_tests][r][i] = merge_pkg::key_t'(value);
                    end
                end
                total_words += run_count[num_tests][RUN_EXPECTED];
                num_tests++;
            end
            code = $fscanf(fd, "%s", token);
        end
        $fclose(fd);
    endtask

    // One producer, each word a full req/ack exchange after a random gap
    task automatic drive_run(input int ch, input int t);
        int i;
        for (i = 0; i < run_count[t][ch]; i++) begin
            repeat (random_delay(3)) @(posedge clock);
            key_in[ch]  <= run_keys[t][ch][i];
            last_in[ch] <= (i == run_count[t][ch] - 1);
            req_in[ch]  <= 1'b1;
            do @(posedge clock); while (!ack_out[ch]);
            req_in[ch] <= 1'b0;
            do @(posedge clock); while (ack_out[ch]);
        end
    endtask

    // Outputs are read on the edge, so they are the values held just before it
    task automatic consume_run(input int t);
        int              i;
        int              n;
        merge_pkg::key_t got_key;
        logic            got_last;
        n = run_count[t][RUN_EXPECTED];
        for (i = 0; i < n; i++) begin
            do @(posedge clock); while (!out_req);
            got_key  = out_key;
            got_last = out_last;
            check_value(test_name[t], 32'(run_keys[t][RUN_EXPECTED][i]), 32'(got_key));
            if (got_last !== (i == n - 1)) begin
                if (got_last) begin
                    $display("Test %s set out_last early on word %0d of %0d", test_name[t],
                             i + 1, n);
                end else begin
                    $display("Test %s is missing out_last on its final word", test_name[t]);
                end
                errors++;
            end
            // A slow consumer holds the port and so throttles the whole pipeline
            repeat (random_delay(5)) @(posedge clock);
            out_ack <= 1'b1;
            do @(posedge clock); while (out_req);
            out_ack <= 1'b0;
        end
    endtask

    // Anything that still comes out after the expected run is a duplicate
    task automatic check_no_extra(input int t);
        repeat (12) begin
            @(posedge clock);
            if (out_req) begin
                $display("Test %s produced an extra output word with key %0d", test_name[t],
                         out_key);
                errors++;
                out_ack <= 1'b1;
                do @(posedge clock); while (out_req);
                out_ack <= 1'b0;
            end
        end
    endtask

    task automatic run_test(input int t);
        fork
            drive_run(0, t);
            drive_run(1, t);
            consume_run(t);
        join
        check_no_extra(t);
    endtask

    task automatic check_reset_state();
        check_value("reset", 32'd0, 32'(out_req));
        check_value("reset", 32'd0, 32'(ack_out[0]));
        check_value("reset", 32'd0, 32'(ack_out[1]));
    endtask

    initial begin
        int t;
        rst_n      <= 1'b0;
        req_in[0]  <= 1'b0;
        req_in[1]  <= 1'b0;
        last_in[0] <= 1'b0;
        last_in[1] <= 1'b0;
        key_in[0]  <= '0;
        key_in[1]  <= '0;
        out_ack    <= 1'b0;
        errors      = 0;
        num_tests   = 0;
        total_words = 0;
        rng_state   = 32'hd5957dc4;
        load_tests();
        watchdog_cycles = total_words * 40 + 200;
        repeat (5) begin
            @(posedge clock);
            check_reset_state();
        end
        rst_n <= 1'b1;
        @(posedge clock);
        check_reset_state();
        for (t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Closing report: %0d errors over %0d tests", errors, num_tests);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Budget grows with the number of merged words in the test file
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout after %0d cycles with %0d errors so far", watchdog_cycles, errors);
        $display("Something failed");
        $finish;
    end

endmodule
